// ==== hdl/filt_pkg.sv ====
package filt_pkg;

    // ----------------------------------------
    // geometry and widths
    // ----------------------------------------
    localparam int PIX_W    = 12;
    localparam int LINE_MAX = 64;
    localparam int WIN      = 7;

    // number of stored lines above the current one
    localparam int N_LINES  = WIN - 1;
    localparam int CENTER   = WIN / 2;

    // column counter / line memory address
    localparam int ADDR_W   = $clog2(LINE_MAX);
    // row counter only has to reach WIN-1, then it holds
    localparam int ROW_W    = $clog2(WIN);

    // ----------------------------------------
    // types
    // ----------------------------------------
    typedef logic [PIX_W-1:0] pix_t;

    typedef struct packed {
        pix_t pix;
        logic de;
        logic sol;
        logic sof;
    } stream_t;

    // [row][col], row 0 is the oldest line, col 0 the leftmost pixel
    typedef pix_t [WIN-1:0][WIN-1:0] win_t;

    typedef struct packed {
        win_t win;
        logic de;
        logic sol;
        logic sof;
    } win_stream_t;

    // index 0 is the line six rows back, index N_LINES-1 the previous line
    typedef pix_t [N_LINES-1:0] line_t;

    typedef enum logic [1:0] {
        MODE_MAX    = 2'd0,
        MODE_MIN    = 2'd1,
        MODE_CENTER = 2'd2
    } filt_mode_t;

endpackage

// ==== hdl/line_buffer_chain.sv ====
module line_buffer_chain
    import filt_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,
    input  stream_t s_i,
    output line_t   lines_o
);

    // memory N_LINES-1 holds the previous line, memory 0 the oldest one
    pix_t mem [N_LINES][LINE_MAX];

    logic [ADDR_W-1:0] wr_addr_q;
    logic [ADDR_W-1:0] addr_cur;

    // write data per memory: each one takes what its younger neighbour shows
    pix_t [N_LINES:0] chain;

    // sol pixel always lands on column 0
    assign addr_cur = s_i.sol ? '0 : wr_addr_q;

    assign chain = {s_i.pix, lines_o};

    // ----------------------------------------
    // write address
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_addr_q <= '0;
        end else if (s_i.de) begin
            wr_addr_q <= addr_cur + 1'b1;
        end
    end

    // ----------------------------------------
    // line memories
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (s_i.de) begin
            for (int k = 0; k < N_LINES; k++) begin
                mem[k][addr_cur] <= chain[k+1];
            end
        end
    end

    // asynchronous read, same column as the incoming pixel
    always_comb begin
        for (int k = 0; k < N_LINES; k++) begin
            lines_o[k] = mem[k][addr_cur];
        end
    end

endmodule

// ==== hdl/window_7x7.sv ====
module window_7x7
    import filt_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  stream_t     s_i,
    input  line_t       lines_i,
    output win_stream_t w_o
);

    win_t win_q;

    // new right-hand column, oldest line at index 0
    pix_t [WIN-1:0] col_in;

    logic [ADDR_W-1:0] col_q;
    logic [ADDR_W-1:0] col_cur;
    logic [ROW_W-1:0]  row_q;
    logic [ROW_W-1:0]  row_cur;

    logic win_full;
    logic de_q;
    logic sol_q;
    logic sof_q;

    // set while output row 0 is being produced, cleared by its first line end
    logic first_row_q;

    assign col_in = {s_i.pix, lines_i};

    // ----------------------------------------
    // position of the incoming pixel
    // ----------------------------------------
    assign col_cur = s_i.sol ? '0 : col_q;

    always_comb begin
        if (s_i.sof) begin
            row_cur = '0;
        end else if (s_i.sol && (row_q != ROW_W'(WIN-1))) begin
            row_cur = row_q + 1'b1;
        end else begin
            // holds once the window has enough rows
            row_cur = row_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            col_q <= '0;
            row_q <= '0;
        end else if (s_i.de) begin
            col_q <= col_cur + 1'b1;
            row_q <= row_cur;
        end
    end

    // window is complete once the pixel sits at row >= 6 and column >= 6
    assign win_full = (col_cur >= ADDR_W'(WIN-1)) && (row_cur == ROW_W'(WIN-1));

    // ----------------------------------------
    // shift register window
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (s_i.de) begin
            for (int r = 0; r < WIN; r++) begin
                for (int c = 0; c < WIN-1; c++) begin
                    win_q[r][c] <= win_q[r][c+1];
                end
                win_q[r][WIN-1] <= col_in[r];
            end
        end
    end

    // ----------------------------------------
    // output flags
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_q  <= 1'b0;
            sol_q <= 1'b0;
            sof_q <= 1'b0;
        end else begin
            de_q  <= s_i.de && win_full;
            // first output of a line comes from input column 6
            sol_q <= s_i.de && win_full && (col_cur == ADDR_W'(WIN-1));
            sof_q <= s_i.de && win_full && (col_cur == ADDR_W'(WIN-1)) && first_row_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            first_row_q <= 1'b0;
        end else if (s_i.de) begin
            if (s_i.sof) begin
                first_row_q <= 1'b1;
            end else if (s_i.sol && row_q == ROW_W'(WIN-1)) begin
                first_row_q <= 1'b0;
            end
        end
    end

    assign w_o = '{win: win_q, de: de_q, sol: sol_q, sof: sof_q};

endmodule

// ==== hdl/window_reduce.sv ====
module window_reduce
    import filt_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  win_stream_t w_i,
    input  filt_mode_t  mode_i,
    output stream_t     m_o
);

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic pix_t vmax(input pix_t [WIN-1:0] v);
        pix_t m;
        m = v[0];
        for (int i = 1; i < WIN; i++) begin
            if (v[i] > m) begin
                m = v[i];
            end
        end
        return m;
    endfunction

    function automatic pix_t vmin(input pix_t [WIN-1:0] v);
        pix_t m;
        m = v[0];
        for (int i = 1; i < WIN; i++) begin
            if (v[i] < m) begin
                m = v[i];
            end
        end
        return m;
    endfunction

    // flags are kept as {de, sol, sof}
    logic [2:0] flg1_q;
    logic [2:0] flg2_q;
    logic [2:0] flg3_q;

    pix_t [WIN-1:0] row_max_q;
    pix_t [WIN-1:0] row_min_q;
    pix_t           center1_q;
    filt_mode_t     mode1_q;

    pix_t       max2_q;
    pix_t       min2_q;
    pix_t       center2_q;
    filt_mode_t mode2_q;

    pix_t pix3_q;

    // ----------------------------------------
    // data path, three stages
    // ----------------------------------------
    always_ff @(posedge clk) begin
        // stage 1: per row
        for (int r = 0; r < WIN; r++) begin
            row_max_q[r] <= vmax(w_i.win[r]);
            row_min_q[r] <= vmin(w_i.win[r]);
        end
        center1_q <= w_i.win[CENTER][CENTER];
        mode1_q   <= mode_i;

        // stage 2: across rows
        max2_q    <= vmax(row_max_q);
        min2_q    <= vmin(row_min_q);
        center2_q <= center1_q;
        mode2_q   <= mode1_q;

        // stage 3: pick the result
        case (mode2_q)
            MODE_MAX: pix3_q <= max2_q;
            MODE_MIN: pix3_q <= min2_q;
            default:  pix3_q <= center2_q;
        endcase
    end

    // flags ride along with the data
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flg1_q <= '0;
            flg2_q <= '0;
            flg3_q <= '0;
        end else begin
            flg1_q <= {w_i.de, w_i.sol, w_i.sof};
            flg2_q <= flg1_q;
            flg3_q <= flg2_q;
        end
    end

    assign m_o = '{pix: pix3_q, de: flg3_q[2], sol: flg3_q[1], sof: flg3_q[0]};

endmodule

// ==== hdl/filter_7x7_top.sv ====
module filter_7x7_top
    import filt_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  stream_t    s_i,
    input  filt_mode_t mode_i,
    output stream_t    m_o
);

    line_t       lines;
    win_stream_t win_s;

    // ----------------------------------------
    // six previous lines for the current column
    // ----------------------------------------
    line_buffer_chain u_line_buffer_chain (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .s_i      (s_i),
        .lines_o  (lines)
    );

    // ----------------------------------------
    // 7x7 neighbourhood and frame position
    // ----------------------------------------
    window_7x7 u_window_7x7 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .s_i      (s_i),
        .lines_i  (lines),
        .w_o      (win_s)
    );

    // ----------------------------------------
    // max / min / centre, 3 cycles
    // ----------------------------------------
    window_reduce u_window_reduce (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .w_i      (win_s),
        .mode_i   (mode_i),
        .m_o      (m_o)
    );

endmodule

// ==== testbench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// expected outputs, in the order the DUT must produce them
stream_t exp_q [$];

// ----------------------------------------
// reference 7x7 model
// ----------------------------------------

// window with its bottom-right corner at (r, c)
function automatic pix_t expected_pixel(int r, int c, filt_mode_t mode);
    pix_t best;
    if (mode == MODE_CENTER) begin
        return img[r-3][c-3];
    end
    best = img[r][c];
    for (int i = r - 6; i <= r; i++) begin
        for (int j = c - 6; j <= c; j++) begin
            if (mode == MODE_MAX && img[i][j] > best) begin
                best = img[i][j];
            end
            if (mode == MODE_MIN && img[i][j] < best) begin
                best = img[i][j];
            end
        end
    end
    return best;
endfunction

// one entry per complete window, raster order
task automatic push_frame_expected(int w, int h, filt_mode_t mode);
    stream_t e;
    for (int r = 6; r < h; r++) begin
        for (int c = 6; c < w; c++) begin
            e.pix = expected_pixel(r, c, mode);
            e.de  = 1'b1;
            e.sol = (c == 6);
            e.sof = (r == 6) && (c == 6);
            exp_q.push_back(e);
        end
    end
endtask

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic check_pix(pix_t got, pix_t want);
    if (got !== want) begin
        stop_on_error($sformatf("FAILED t=%0t m_o.pix: got 0x%03h, expected 0x%03h",
                                $time, got, want));
    end
endtask

task automatic check_flags(stream_t got, stream_t want);
    if (got.sol !== want.sol) begin
        stop_on_error($sformatf("FAILED t=%0t m_o.sol: got %0b, expected %0b",
                                $time, got.sol, want.sol));
    end
    if (got.sof !== want.sof) begin
        stop_on_error($sformatf("FAILED t=%0t m_o.sof: got %0b, expected %0b",
                                $time, got.sof, want.sof));
    end
endtask

`endif

// ==== testbench/tb_filter_7x7.sv ====
module tb_filter_7x7 import filt_pkg::*; ();

    localparam int N_FRAMES      = 9;
    localparam int DRAIN_TIMEOUT = 200;
    localparam int SETTLE_CYCLES = 20;

    typedef struct packed {
        int unsigned w;
        int unsigned h;
        filt_mode_t  mode;
        bit          rnd;
        int unsigned gap_pct;
    } frame_cfg_t;

    logic       clk;
    logic       arst_n_i;
    stream_t    s_i;
    filt_mode_t mode_i;
    stream_t    m_o;

    frame_cfg_t frame_tab [N_FRAMES];
    pix_t       img [LINE_MAX][LINE_MAX];

    filter_7x7_top UUT (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .s_i      (s_i),
        .mode_i   (mode_i),
        .m_o      (m_o)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    `include "tb_model.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // frame table
    // ----------------------------------------
    task automatic load_frame_table();
        frame_tab[0] = '{w: 16, h: 12, mode: MODE_MAX,    rnd: 1'b0, gap_pct: 0};
        frame_tab[1] = '{w: 20, h: 10, mode: MODE_MIN,    rnd: 1'b1, gap_pct: 0};
        frame_tab[2] = '{w: 18, h: 11, mode: MODE_CENTER, rnd: 1'b1, gap_pct: 0};
        // widest line, directly after a narrower frame
        frame_tab[3] = '{w: 64, h: 10, mode: MODE_CENTER, rnd: 1'b1, gap_pct: 0};
        frame_tab[4] = '{w: 25, h: 8,  mode: MODE_MAX,    rnd: 1'b1, gap_pct: 30};
        frame_tab[5] = '{w: 11, h: 9,  mode: MODE_MAX,    rnd: 1'b0, gap_pct: 40};
        // smallest frame, a single output pixel
        frame_tab[6] = '{w: 7,  h: 7,  mode: MODE_MIN,    rnd: 1'b1, gap_pct: 20};
        frame_tab[7] = '{w: 64, h: 8,  mode: MODE_MIN,    rnd: 1'b1, gap_pct: 15};
        frame_tab[8] = '{w: 33, h: 13, mode: MODE_CENTER, rnd: 1'b1, gap_pct: 35};
    endtask

    // ----------------------------------------
    // driver helpers, all on the falling edge
    // ----------------------------------------
    task automatic drive_idle();
        @(negedge clk);
        s_i = '0;
    endtask

    task automatic drive_pixel(pix_t p, logic sol, logic sof);
        @(negedge clk);
        s_i = '{pix: p, de: 1'b1, sol: sol, sof: sof};
    endtask

    task automatic fill_image(int w, int h, bit rnd);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                img[r][c] = rnd ? pix_t'($urandom) : pix_t'(r * w + c);
            end
        end
    endtask

    task automatic send_frame(int w, int h, int unsigned gap_pct);
        int unsigned gap;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                if (gap_pct != 0 && $urandom_range(99) < gap_pct) begin
                    gap = $urandom_range(3, 1);
                    repeat (gap) drive_idle();
                end
                drive_pixel(img[r][c], c == 0, (r == 0) && (c == 0));
            end
        end
    endtask

    task automatic wait_for_drain(input int max_cycles, output bit drained);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        drained = (exp_q.size() == 0);
    endtask

    // ----------------------------------------
    // monitor
    // ----------------------------------------
    initial begin : monitor
        stream_t want;
        forever begin
            @(negedge clk);
            if (m_o.de === 1'b1) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("the DUT produced an output pixel when none was expected");
                end else begin
                    want = exp_q.pop_front();
                    check_flags(m_o, want);
                    check_pix(m_o.pix, want.pix);
                end
            end
        end
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : driver
        bit drained;
        void'($urandom(32'h3f74));
        arst_n_i = 1'b0;
        s_i      = '0;
        load_frame_table();
        mode_i   = frame_tab[0].mode;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        for (int f = 0; f < N_FRAMES; f++) begin
            // mode only changes once the previous frame has left the pipeline
            if (frame_tab[f].mode != mode_i) begin
                drive_idle();
                wait_for_drain(DRAIN_TIMEOUT, drained);
                if (!drained) begin
                    stop_on_error("timeout: a frame did not finish before the mode change");
                end
                mode_i = frame_tab[f].mode;
            end
            fill_image(frame_tab[f].w, frame_tab[f].h, frame_tab[f].rnd);
            push_frame_expected(frame_tab[f].w, frame_tab[f].h, frame_tab[f].mode);
            send_frame(frame_tab[f].w, frame_tab[f].h, frame_tab[f].gap_pct);
        end

        drive_idle();
        wait_for_drain(DRAIN_TIMEOUT, drained);
        // catch stray outputs after the last frame
        repeat (SETTLE_CYCLES) @(negedge clk);
        if (drained && exp_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_on_error($sformatf("timeout: %0d expected output pixels never appeared",
                                    exp_q.size()));
        end
    end

endmodule

// ==== filter_7x7.f ====
+incdir+testbench
hdl/filt_pkg.sv
hdl/line_buffer_chain.sv
hdl/window_7x7.sv
hdl/window_reduce.sv
hdl/filter_7x7_top.sv
testbench/tb_filter_7x7.sv

// ==== Makefile ====
# Verilator build and run for the 7x7 neighbourhood filter

VERILATOR ?= verilator
TOP       ?= tb_filter_7x7
RTL_TOP   ?= filter_7x7_top
SEED      ?= 16244
FILELIST  ?= filter_7x7.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

RTL_SRCS := hdl/filt_pkg.sv hdl/line_buffer_chain.sv hdl/window_7x7.sv \
            hdl/window_reduce.sv hdl/filter_7x7_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log is searched for the pass line, so a fatal stop fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
